// File: source/mem_stage_pkg.sv
// Memory stage package with data widths, vector types and store-operation codes

package mem_stage_pkg;

        // ------------------------------------------------------------------
        // Widths
        // ------------------------------------------------------------------
        localparam int NUM_LANES = 4;           // Byte lanes per data word
        localparam int BYTE_W    = 8;

        // ------------------------------------------------------------------
        // Vector types
        // ------------------------------------------------------------------
        typedef logic [NUM_LANES*BYTE_W-1:0]    word_t;         // Data or address word
        typedef logic [BYTE_W-1:0]              byte_t;
        typedef logic [NUM_LANES-1:0]           be_t;           // Bit k enables lane k
        typedef logic [$clog2(NUM_LANES)-1:0]   offset_t;       // Address bits 1:0
        typedef logic [$clog2(NUM_LANES)-1:0]   lane_idx_t;     // Lane number or byte shift
        typedef logic [4:0]                     reg_num_t;
        typedef logic [2:0]                     store_op_t;
        typedef logic [2:0]                     align_op_t;     // Used only in writeback
        typedef logic [1:0]                     wbdata_sel_t;

        // ------------------------------------------------------------------
        // Store-operation codes
        // ------------------------------------------------------------------
        // Bits 1:0 give the access size, bit 2 splits SWR from SWL
        localparam store_op_t ST_SB  = 3'b000;
        localparam store_op_t ST_SH  = 3'b001;
        localparam store_op_t ST_SWL = 3'b010;
        localparam store_op_t ST_SWR = 3'b110;
        localparam store_op_t ST_SW  = 3'b011;

endpackage

// File: source/store_decode.sv
// Store decoder turning operation, offset and endianness into byte shift and lane span
`timescale 1ns/1ps

module store_decode
(
        input  logic                            big_endian,
        input  mem_stage_pkg::store_op_t        store_op,
        input  mem_stage_pkg::offset_t          offset,
        output mem_stage_pkg::lane_idx_t        shift,
        output logic                            shift_right,
        output mem_stage_pkg::lane_idx_t        lane_lo,
        output mem_stage_pkg::lane_idx_t        lane_hi
);

        import mem_stage_pkg::*;

        lane_idx_t      byte_pos;               // Lane of the addressed byte
        lane_idx_t      swl_shift;              // Right shift for SWL
        lane_idx_t      half_base;              // Low lane of a halfword

        // Big-endian mirrors the lane order
        assign byte_pos  = big_endian ? ~offset : offset;
        assign swl_shift = ~byte_pos;           // 3 minus byte position
        assign half_base = {byte_pos[1], 1'b0};

        // ------------------------------------------------------------------
        // Shift and enabled lanes per operation
        // ------------------------------------------------------------------
        always_comb
        begin
                shift       = '0;
                shift_right = 1'b0;
                lane_lo     = '0;
                lane_hi     = lane_idx_t'(NUM_LANES - 1);
                case (store_op[1:0])
                        ST_SB[1:0]:
                        begin
                                shift   = byte_pos;
                                lane_lo = byte_pos;
                                lane_hi = byte_pos;
                        end
                        ST_SH[1:0]:
                        begin
                                shift   = half_base;
                                lane_lo = half_base;
                                lane_hi = half_base + lane_idx_t'(1);
                        end
                        ST_SWL[1:0]:
                        begin
                                if (store_op[2] == ST_SWR[2])
                                begin
                                        // SWR fills from the addressed byte up
                                        shift   = byte_pos;
                                        lane_lo = byte_pos;
                                end
                                else
                                begin
                                        // SWL moves the upper bytes down
                                        shift       = swl_shift;
                                        shift_right = 1'b1;
                                        lane_hi     = byte_pos;
                                end
                        end
                        default:
                        begin
                                // SW keeps the full-word defaults
                        end
                endcase
        end

endmodule

// File: source/store_lane.sv
// Store byte lane selecting its write-data byte and byte enable
`timescale 1ns/1ps

module store_lane
#(
        parameter int LANE = 0
)
(
        input  logic                            memwrite,
        input  mem_stage_pkg::word_t            b_bus,
        input  mem_stage_pkg::lane_idx_t        shift,
        input  logic                            shift_right,
        input  mem_stage_pkg::lane_idx_t        lane_lo,
        input  mem_stage_pkg::lane_idx_t        lane_hi,
        output mem_stage_pkg::byte_t            wbyte,
        output logic                            be
);

        import mem_stage_pkg::*;

        int             src_idx;                // Source byte index that may fall outside b_bus

        assign src_idx = shift_right ? LANE + int'(shift) : LANE - int'(shift);

        // ------------------------------------------------------------------
        // Write data byte
        // ------------------------------------------------------------------
        always_comb
        begin
                wbyte = '0;
                if (memwrite && src_idx >= 0 && src_idx < NUM_LANES)
                begin
                        wbyte = b_bus[src_idx*BYTE_W +: BYTE_W];
                end
        end

        // Enable does not depend on memwrite
        assign be = (LANE >= int'(lane_lo)) && (LANE <= int'(lane_hi));

endmodule

// File: source/mem_wb_reg.sv
// MEM/WB pipeline register with stall and per-field load enables
`timescale 1ns/1ps

module mem_wb_reg
(
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            stall,
        input  logic                            memread,
        input  logic                            mhi_en,
        input  logic                            mlo_en,
        input  mem_stage_pkg::align_op_t        align_op,
        input  logic                            mulreg_sel,
        input  mem_stage_pkg::wbdata_sel_t      wbdata_sel,
        input  logic                            regwrite,
        input  mem_stage_pkg::reg_num_t         write_num,
        input  mem_stage_pkg::word_t            result_bus,
        input  mem_stage_pkg::word_t            rdata_bus,
        input  mem_stage_pkg::word_t            mul_hi,
        input  mem_stage_pkg::word_t            mul_lo,
        input  mem_stage_pkg::offset_t          offset,
        output mem_stage_pkg::align_op_t        wb_align_op,
        output logic                            wb_mulreg_sel,
        output mem_stage_pkg::wbdata_sel_t      wb_wbdata_sel,
        output logic                            wb_regwrite,
        output mem_stage_pkg::reg_num_t         wb_write_num,
        output mem_stage_pkg::word_t            wb_result_bus,
        output mem_stage_pkg::word_t            wb_rdata_bus,
        output mem_stage_pkg::word_t            wb_mul_hi,
        output mem_stage_pkg::word_t            wb_mul_lo,
        output mem_stage_pkg::offset_t          wb_dmem_offset
);

        import mem_stage_pkg::*;

        logic           ld_en;                  // Whole register advances
        logic           mdr_ld;
        logic           hi_ld;
        logic           lo_ld;

        assign ld_en  = ~stall;
        assign mdr_ld = memread & ld_en;
        assign hi_ld  = mhi_en & ld_en;
        assign lo_ld  = mlo_en & ld_en;

        // ------------------------------------------------------------------
        // Writeback controls, ALU result and byte offset
        // ------------------------------------------------------------------
        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        wb_align_op    <= '0;
                        wb_mulreg_sel  <= 1'b0;
                        wb_wbdata_sel  <= '0;
                        wb_regwrite    <= 1'b0;
                        wb_write_num   <= '0;
                        wb_result_bus  <= '0;
                        wb_dmem_offset <= '0;
                end
                else if (ld_en)
                begin
                        wb_align_op    <= align_op;
                        wb_mulreg_sel  <= mulreg_sel;
                        wb_wbdata_sel  <= wbdata_sel;
                        wb_regwrite    <= regwrite;
                        wb_write_num   <= write_num;
                        wb_result_bus  <= result_bus;
                        wb_dmem_offset <= offset;       // Load alignment in WB
                end
        end

        // ------------------------------------------------------------------
        // MDR and multiplier results, each with its own enable
        // ------------------------------------------------------------------
        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        wb_rdata_bus <= '0;
                        wb_mul_hi    <= '0;
                        wb_mul_lo    <= '0;
                end
                else
                begin
                        if (mdr_ld)
                                wb_rdata_bus <= rdata_bus;
                        if (hi_ld)
                                wb_mul_hi <= mul_hi;
                        if (lo_ld)
                                wb_mul_lo <= mul_lo;
                end
        end

endmodule

// File: source/cpu_mem.sv
// MIPS memory stage driving the data-memory port and the MEM/WB register
`timescale 1ns/1ps

module cpu_mem
(
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            stall,
        // Control from EX/MEM
        input  logic                            big_endian,
        input  logic                            m_memwrite,
        input  logic                            m_memread,
        input  mem_stage_pkg::store_op_t        m_store_op,
        input  logic                            m_mhi_en,
        input  logic                            m_mlo_en,
        input  mem_stage_pkg::align_op_t        m_align_op,
        input  logic                            m_mulreg_sel,
        input  mem_stage_pkg::wbdata_sel_t      m_wbdata_sel,
        input  logic                            m_regwrite,
        // Datapath from EX/MEM
        input  mem_stage_pkg::word_t            m_result_bus,
        input  mem_stage_pkg::word_t            m_b_bus,
        input  mem_stage_pkg::reg_num_t         m_write_num,
        input  mem_stage_pkg::word_t            mul_hi,
        input  mem_stage_pkg::word_t            mul_lo,
        input  mem_stage_pkg::word_t            dmem_rdatabus,
        // Data-memory port
        output mem_stage_pkg::word_t            dmem_addr,
        output mem_stage_pkg::word_t            dmem_wdatabus,
        output logic                            dmem_request,
        output mem_stage_pkg::be_t              dmem_be,
        output logic                            dmem_write,
        // To writeback
        output mem_stage_pkg::align_op_t        wb_align_op,
        output logic                            wb_mulreg_sel,
        output mem_stage_pkg::wbdata_sel_t      wb_wbdata_sel,
        output logic                            wb_regwrite,
        output mem_stage_pkg::reg_num_t         wb_write_num,
        output mem_stage_pkg::word_t            wb_result_bus,
        output mem_stage_pkg::word_t            wb_rdata_bus,
        output mem_stage_pkg::word_t            wb_mul_hi,
        output mem_stage_pkg::word_t            wb_mul_lo,
        output mem_stage_pkg::offset_t          wb_dmem_offset
);

        import mem_stage_pkg::*;

        offset_t        offset;
        lane_idx_t      shift;
        logic           shift_right;
        lane_idx_t      lane_lo;
        lane_idx_t      lane_hi;

        // ------------------------------------------------------------------
        // Memory port strobes
        // ------------------------------------------------------------------
        assign offset       = m_result_bus[1:0];
        assign dmem_addr    = m_result_bus;
        assign dmem_request = m_memwrite | m_memread;
        assign dmem_write   = m_memwrite;

        store_decode u_decode
        (
                .big_endian     (big_endian),
                .store_op       (m_store_op),
                .offset         (offset),
                .shift          (shift),
                .shift_right    (shift_right),
                .lane_lo        (lane_lo),
                .lane_hi        (lane_hi)
        );

        // One aligner per byte lane
        for (genvar g = 0; g < NUM_LANES; g++)
        begin : gen_lane
                store_lane #(.LANE(g)) u_lane
                (
                        .memwrite       (m_memwrite),
                        .b_bus          (m_b_bus),
                        .shift          (shift),
                        .shift_right    (shift_right),
                        .lane_lo        (lane_lo),
                        .lane_hi        (lane_hi),
                        .wbyte          (dmem_wdatabus[g*BYTE_W +: BYTE_W]),
                        .be             (dmem_be[g])
                );
        end

        // ------------------------------------------------------------------
        // MEM/WB register
        // ------------------------------------------------------------------
        mem_wb_reg u_mem_wb
        (
                .clk            (clk),
                .rst_n          (rst_n),
                .stall          (stall),
                .memread        (m_memread),
                .mhi_en         (m_mhi_en),
                .mlo_en         (m_mlo_en),
                .align_op       (m_align_op),
                .mulreg_sel     (m_mulreg_sel),
                .wbdata_sel     (m_wbdata_sel),
                .regwrite       (m_regwrite),
                .write_num      (m_write_num),
                .result_bus     (m_result_bus),
                .rdata_bus      (dmem_rdatabus),        // Load data into MDR
                .mul_hi         (mul_hi),
                .mul_lo         (mul_lo),
                .offset         (offset),
                .wb_align_op    (wb_align_op),
                .wb_mulreg_sel  (wb_mulreg_sel),
                .wb_wbdata_sel  (wb_wbdata_sel),
                .wb_regwrite    (wb_regwrite),
                .wb_write_num   (wb_write_num),
                .wb_result_bus  (wb_result_bus),
                .wb_rdata_bus   (wb_rdata_bus),
                .wb_mul_hi      (wb_mul_hi),
                .wb_mul_lo      (wb_mul_lo),
                .wb_dmem_offset (wb_dmem_offset)
        );

endmodule

// File: verif/tb_cpu_mem.sv
// Testbench for the memory stage, checking the store path and the MEM/WB register
`timescale 1ns/1ps

module tb_cpu_mem;

        import mem_stage_pkg::*;

        localparam int TEST_CYCLES    = 10 + 200 + 200 + 50 + 100 + 100 + 6;
        localparam int TIMEOUT_CYCLES = TEST_CYCLES + 50;

        logic           clk;
        logic           rst_n;
        logic           stall;
        logic           big_endian;
        logic           m_memwrite;
        logic           m_memread;
        store_op_t      m_store_op;
        logic           m_mhi_en;
        logic           m_mlo_en;
        align_op_t      m_align_op;
        logic           m_mulreg_sel;
        wbdata_sel_t    m_wbdata_sel;
        logic           m_regwrite;
        word_t          m_result_bus;
        word_t          m_b_bus;
        reg_num_t       m_write_num;
        word_t          mul_hi;
        word_t          mul_lo;
        word_t          dmem_rdatabus;
        word_t          dmem_addr;
        word_t          dmem_wdatabus;
        logic           dmem_request;
        be_t            dmem_be;
        logic           dmem_write;
        align_op_t      wb_align_op;
        logic           wb_mulreg_sel;
        wbdata_sel_t    wb_wbdata_sel;
        logic           wb_regwrite;
        reg_num_t       wb_write_num;
        word_t          wb_result_bus;
        word_t          wb_rdata_bus;
        word_t          wb_mul_hi;
        word_t          wb_mul_lo;
        offset_t        wb_dmem_offset;

        // Model of the MEM/WB register
        align_op_t      exp_align_op;
        logic           exp_mulreg_sel;
        wbdata_sel_t    exp_wbdata_sel;
        logic           exp_regwrite;
        reg_num_t       exp_write_num;
        word_t          exp_result;
        word_t          exp_rdata;
        word_t          exp_hi;
        word_t          exp_lo;
        offset_t        exp_offset;

        logic [31:0]    lfsr_state;
        logic           checking;               // Set once reset is over
        int             checks;
        int             errors;
        int             cycles;

        cpu_mem u_dut
        (
                .clk(clk), .rst_n(rst_n), .stall(stall), .big_endian(big_endian),
                .m_memwrite(m_memwrite), .m_memread(m_memread), .m_store_op(m_store_op),
                .m_mhi_en(m_mhi_en), .m_mlo_en(m_mlo_en), .m_align_op(m_align_op),
                .m_mulreg_sel(m_mulreg_sel), .m_wbdata_sel(m_wbdata_sel),
                .m_regwrite(m_regwrite), .m_result_bus(m_result_bus), .m_b_bus(m_b_bus),
                .m_write_num(m_write_num), .mul_hi(mul_hi), .mul_lo(mul_lo),
                .dmem_rdatabus(dmem_rdatabus), .dmem_addr(dmem_addr),
                .dmem_wdatabus(dmem_wdatabus), .dmem_request(dmem_request),
                .dmem_be(dmem_be), .dmem_write(dmem_write), .wb_align_op(wb_align_op),
                .wb_mulreg_sel(wb_mulreg_sel), .wb_wbdata_sel(wb_wbdata_sel),
                .wb_regwrite(wb_regwrite), .wb_write_num(wb_write_num),
                .wb_result_bus(wb_result_bus), .wb_rdata_bus(wb_rdata_bus),
                .wb_mul_hi(wb_mul_hi), .wb_mul_lo(wb_mul_lo),
                .wb_dmem_offset(wb_dmem_offset)
        );

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // ------------------------------------------------------------------
        // Random source and reference model
        // ------------------------------------------------------------------
        // Galois form of x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                if (s[0])
                        return (s >> 1) ^ 32'h8020_0003;
                return s >> 1;
        endfunction

        task automatic draw(input int n, output logic [31:0] v);
                v = '0;
                for (int i = 0; i < n; i++)
                begin
                        v = {v[30:0], lfsr_state[0]};   // One step per bit
                        lfsr_state = lfsr_next(lfsr_state);
                end
        endtask

        function automatic store_op_t op_code(input int idx);
                case (idx)
                        0:       return ST_SB;
                        1:       return ST_SH;
                        2:       return ST_SWL;
                        3:       return ST_SWR;
                        default: return ST_SW;
                endcase
        endfunction

        // Returns byte enables above the write data
        function automatic logic [35:0] expected_store(input logic big, input store_op_t op,
                                                       input offset_t off, input word_t b,
                                                       input logic wr);
                int     s;
                int     r;
                int     base;
                word_t  wd;
                be_t    be;
                s = big ? 3 - int'(off) : int'(off);
                r = 3 - s;                      // SWL right shift
                base = (off[1] ^ big) ? 2 : 0;
                case (op)
                        ST_SB:
                        begin
                                wd = b << (8 * s);
                                be = 4'b0001 << s;
                        end
                        ST_SH:
                        begin
                                wd = b << (8 * base);
                                be = 4'b0011 << base;
                        end
                        ST_SWR:
                        begin
                                wd = b << (8 * s);
                                be = 4'b1111 << s;
                        end
                        ST_SWL:
                        begin
                                wd = b >> (8 * r);
                                be = 4'b1111 >> r;
                        end
                        default:
                        begin
                                wd = b;
                                be = 4'b1111;
                        end
                endcase
                if (!wr)
                        wd = '0;
                return {be, wd};
        endfunction

        task automatic check_val(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("ERR %s expected %h actual %h", name, exp, got);
                end
        endtask

        // ------------------------------------------------------------------
        // Comparison at the falling edge, after inputs settle
        // ------------------------------------------------------------------
        initial
        begin
                logic [35:0] exp_st;
                forever
                begin
                        @(negedge clk);
                        if (checking)
                        begin
                                exp_st = expected_store(big_endian, m_store_op,
                                                        m_result_bus[1:0], m_b_bus, m_memwrite);
                                check_val("dmem_wdatabus", exp_st[31:0], dmem_wdatabus);
                                check_val("dmem_be", 32'(exp_st[35:32]), 32'(dmem_be));
                                check_val("dmem_addr", m_result_bus, dmem_addr);
                                check_val("dmem_request", 32'(m_memwrite | m_memread),
                                          32'(dmem_request));
                                check_val("dmem_write", 32'(m_memwrite), 32'(dmem_write));
                                check_val("wb_align_op", 32'(exp_align_op), 32'(wb_align_op));
                                check_val("wb_mulreg_sel", 32'(exp_mulreg_sel),
                                          32'(wb_mulreg_sel));
                                check_val("wb_wbdata_sel", 32'(exp_wbdata_sel),
                                          32'(wb_wbdata_sel));
                                check_val("wb_regwrite", 32'(exp_regwrite), 32'(wb_regwrite));
                                check_val("wb_write_num", 32'(exp_write_num),
                                          32'(wb_write_num));
                                check_val("wb_result_bus", exp_result, wb_result_bus);
                                check_val("wb_rdata_bus", exp_rdata, wb_rdata_bus);
                                check_val("wb_mul_hi", exp_hi, wb_mul_hi);
                                check_val("wb_mul_lo", exp_lo, wb_mul_lo);
                                check_val("wb_dmem_offset", 32'(exp_offset),
                                          32'(wb_dmem_offset));
                        end
                        // What the next rising edge will load
                        if (!rst_n)
                        begin
                                exp_align_op   = '0;
                                exp_mulreg_sel = 1'b0;
                                exp_wbdata_sel = '0;
                                exp_regwrite   = 1'b0;
                                exp_write_num  = '0;
                                exp_result     = '0;
                                exp_rdata      = '0;
                                exp_hi         = '0;
                                exp_lo         = '0;
                                exp_offset     = '0;
                        end
                        else if (!stall)
                        begin
                                exp_align_op   = m_align_op;
                                exp_mulreg_sel = m_mulreg_sel;
                                exp_wbdata_sel = m_wbdata_sel;
                                exp_regwrite   = m_regwrite;
                                exp_write_num  = m_write_num;
                                exp_result     = m_result_bus;
                                exp_offset     = m_result_bus[1:0];
                                if (m_memread)
                                        exp_rdata = dmem_rdatabus;
                                if (m_mhi_en)
                                        exp_hi = mul_hi;
                                if (m_mlo_en)
                                        exp_lo = mul_lo;
                        end
                end
        end

        // ------------------------------------------------------------------
        // Stimulus
        // ------------------------------------------------------------------
        // wr_mode 0 keeps memwrite low, 1 high, 2 random
        task automatic drive_cycle(input logic be_val, input int wr_mode, input logic stall_on);
                logic [31:0] r;
                big_endian = be_val;
                draw(32, r);
                m_result_bus = r;
                draw(32, r);
                m_b_bus = r;
                draw(3, r);
                m_store_op = op_code(int'(r % 5));
                draw(1, r);
                m_memwrite = (wr_mode == 2) ? r[0] : (wr_mode == 1);
                draw(4, r);
                m_memread    = r[0];
                m_mhi_en     = r[1];
                m_mlo_en     = r[2];
                m_mulreg_sel = r[3];
                draw(11, r);
                m_align_op   = r[2:0];
                m_wbdata_sel = r[4:3];
                m_write_num  = r[9:5];
                m_regwrite   = r[10];
                draw(32, r);
                mul_hi = r;
                draw(32, r);
                mul_lo = r;
                draw(32, r);
                dmem_rdatabus = r;
                draw(1, r);
                stall = stall_on & r[0];
        endtask

        task automatic run_test(input string name, input int n, input logic be_val,
                                input int wr_mode, input logic stall_on);
                int err_start;
                err_start = errors;
                repeat (n)
                begin
                        @(posedge clk);
                        #2;
                        drive_cycle(be_val, wr_mode, stall_on);
                end
                @(negedge clk);
                #1;                             // Let the last comparison finish
                $display("test %s: %0d cycles, %0d errors", name, n, errors - err_start);
        endtask

        initial
        begin
                int err_start;
                lfsr_state = 32'd7;
                checking = 1'b0;
                checks = 0;
                errors = 0;
                rst_n = 1'b0;
                stall = 1'b0;
                big_endian = 1'b0;
                m_memwrite = 1'b0;
                m_store_op = ST_SB;
                // Busy inputs during reset, which the register must not load
                m_memread = 1'b1;
                m_mhi_en = 1'b1;
                m_mlo_en = 1'b1;
                m_align_op = '1;
                m_mulreg_sel = 1'b1;
                m_wbdata_sel = '1;
                m_regwrite = 1'b1;
                m_result_bus = '1;
                m_b_bus = '1;
                m_write_num = '1;
                mul_hi = '1;
                mul_lo = '1;
                dmem_rdatabus = '1;

                repeat (10) @(posedge clk);
                #2;
                rst_n = 1'b1;
                err_start = errors;
                check_val("wb_align_op", 32'h0, 32'(wb_align_op));
                check_val("wb_mulreg_sel", 32'h0, 32'(wb_mulreg_sel));
                check_val("wb_wbdata_sel", 32'h0, 32'(wb_wbdata_sel));
                check_val("wb_regwrite", 32'h0, 32'(wb_regwrite));
                check_val("wb_write_num", 32'h0, 32'(wb_write_num));
                check_val("wb_result_bus", 32'h0, wb_result_bus);
                check_val("wb_rdata_bus", 32'h0, wb_rdata_bus);
                check_val("wb_mul_hi", 32'h0, wb_mul_hi);
                check_val("wb_mul_lo", 32'h0, wb_mul_lo);
                check_val("wb_dmem_offset", 32'h0, 32'(wb_dmem_offset));
                $display("test reset: %0d errors", errors - err_start);
                checking = 1'b1;

                run_test("little_endian_stores", 200, 1'b0, 1, 1'b0);
                run_test("big_endian_stores", 200, 1'b1, 1, 1'b0);
                run_test("no_write_data", 50, 1'b0, 0, 1'b0);
                run_test("pipeline_register", 100, 1'b0, 2, 1'b0);
                run_test("stall", 100, 1'b1, 2, 1'b1);

                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display("All checks passed");
                else
                        $display("Checks failed");
                $finish;
        end

        // Run limit
        initial
        begin
                cycles = 0;
                while (cycles < TIMEOUT_CYCLES)
                begin
                        @(posedge clk);
                        cycles++;
                end
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Checks failed");
                $finish;
        end

endmodule

// File: list.f
source/mem_stage_pkg.sv
source/store_decode.sv
source/store_lane.sv
source/mem_wb_reg.sv
source/cpu_mem.sv
verif/tb_cpu_mem.sv

// File: run.sh
#!/bin/sh
# Build the memory stage testbench with Verilator and run it into a log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_cpu_mem -o tb_cpu_mem
status=$?
if [ $status -ne 0 ]; then
        echo "Verilator build failed with status $status"
        exit 1
fi

./obj_dir/tb_cpu_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -q "Checks failed" "$LOG"; then
        echo "Simulation reported failures"
        exit 1
fi

echo "Simulation passed"
exit 0
